// ==== logic/memPkg.sv ====
`default_nettype none

package memPkg;

    // Widths with a meaning of their own
    typedef logic [31:0] wordT;      // Data word on the bus and in the RAM
    typedef logic [31:0] byteAddrT;  // Byte address as issued by the core
    typedef logic [1:0]  accSizeT;   // Access size tag

    // Access size codes, same encoding as the core's width select
    localparam accSizeT sizeWord = 2'b00;
    localparam accSizeT sizeByte = 2'b01;
    localparam accSizeT sizeHalf = 2'b10;
    // Code 3 is illegal and is answered with err

    // Address bit 16 splits memory (clear) from registers (set)
    localparam int regWinBit = 16;

    // Register byte offsets inside the register window
    localparam logic [3:0] regProtectLimit = 4'h0;  // RW word index, stores below it fail
    localparam logic [3:0] regFaultCount   = 4'h4;  // RO, any write clears
    localparam logic [3:0] regFaultAddr    = 4'h8;  // RO, last faulting byte address

    // Master side of the Wishbone classic bus
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        byteAddrT adr;
        wordT     dat;
        accSizeT  size;          // Address tag
        logic     unsignedLoad;  // Address tag, zero-extend sub-word loads
    } wbReqT;

    // Slave answer, ack or err for one cycle
    typedef struct packed {
        logic ack;
        logic err;
        wordT dat;
    } wbRspT;

endpackage

`default_nettype wire

// ==== logic/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

// Byte-lane data RAM, synchronous read for block RAM mapping
module dataMem
    import memPkg::*;
#(
    parameter int addrWidth = 10
) (
    input  logic                 clk,
    input  logic                 en,
    input  logic                 we,
    input  logic [addrWidth-1:0] wordIdx,
    input  accSizeT              size,
    input  logic [1:0]           lane,     // Low address bits
    input  wordT                 wdata,
    output wordT                 rdata     // Lane-aligned, upper bits zero
);

    localparam int depth = 2 ** addrWidth;

    wordT       ram [depth];
    logic [3:0] laneWe;    // Per-byte write strobes
    wordT       laneData;  // Store data replicated across lanes
    wordT       rawQ;      // Registered RAM word
    accSizeT    sizeQ;
    logic [1:0] laneQ;

    // Lane strobes from size and address
    always_comb begin
        laneWe   = 4'b0000;
        laneData = wdata;
        case (size)
            sizeWord: laneWe = 4'b1111;
            sizeHalf: begin
                laneWe   = lane[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
                laneData = {2{wdata[15:0]}};
            end
            sizeByte: begin
                laneWe   = 4'b0001 << lane;
                laneData = {4{wdata[7:0]}};
            end
            default: laneWe = 4'b0000;  // Never enabled, slave faults it
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we && laneWe[i]) begin
                    ram[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
                end
            end
            rawQ  <= ram[wordIdx];  // Read-first, stores ignore it
            sizeQ <= size;          // Kept for the alignment shift
            laneQ <= lane;
        end
    end

    // Shift the selected part down to bit 0 in the ack cycle
    always_comb begin
        case (sizeQ)
            sizeHalf: begin
                if (laneQ[1]) begin
                    rdata = {16'h0000, rawQ[31:16]};
                end else begin
                    rdata = {16'h0000, rawQ[15:0]};
                end
            end
            sizeByte: rdata = {24'h000000, rawQ[8*laneQ +: 8]};
            default:  rdata = rawQ;  // Word
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/loadFormat.sv ====
`timescale 1ns/1ps
`default_nettype none

// Sign or zero extension of lane-aligned load data
module loadFormat
    import memPkg::*;
(
    input  accSizeT size,
    input  logic    unsignedLoad,
    input  wordT    rawData,      // Already shifted down by the RAM
    output wordT    loadData
);

    logic byteFill;  // Extension bit for byte loads
    logic halfFill;  // Extension bit for halfword loads

    // Zero fill when the unsigned tag is set
    assign byteFill = rawData[7] && !unsignedLoad;
    assign halfFill = rawData[15] && !unsignedLoad;

    always_comb begin
        case (size)
            sizeByte: begin
                loadData = {{24{byteFill}}, rawData[7:0]};   // LB / LBU
            end
            sizeHalf: begin
                loadData = {{16{halfFill}}, rawData[15:0]};  // LH / LHU
            end
            default: begin
                loadData = rawData;  // LW passes through
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/wbMemSlave.sv ====
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic slave in front of the data RAM and control registers
module wbMemSlave
    import memPkg::*;
#(
    parameter int addrWidth = 10
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  wbReqT                bus,
    output wbRspT                rsp,
    output logic                 memEn,
    output logic                 memWe,
    output logic [addrWidth-1:0] wordIdx,
    output accSizeT              size,
    output logic [1:0]           lane,
    output wordT                 wdata,
    output logic                 regSel,
    output logic                 regWe,
    output logic [1:0]           regOffset,
    output wordT                 regWdata,
    output logic                 faultPulse,
    output byteAddrT             faultAddr,
    output accSizeT              fmtSize,      // Registered at accept for the formatter
    output logic                 fmtUnsigned,
    input  logic [addrWidth-1:0] protectLimit,
    input  wordT                 memLoadData,
    input  wordT                 regRdata
);

    logic ackQ;
    logic errQ;
    logic srcRegQ;     // Registers answered the read
    logic accept;
    logic isReg;
    logic misaligned;
    logic regBad;
    logic protFault;
    logic fault;

    // One request in flight, busy while ack or err is up
    assign accept = bus.cyc && bus.stb && !ackQ && !errQ;
    assign isReg  = bus.adr[regWinBit];

    always_comb begin
        case (bus.size)
            sizeWord: misaligned = bus.adr[1:0] != 2'b00;
            sizeHalf: misaligned = bus.adr[0];
            sizeByte: misaligned = 1'b0;
            default:  misaligned = 1'b1;  // Code 3
        endcase
    end

    assign regBad    = isReg && (bus.size != sizeWord);  // Registers are word only
    assign protFault = !isReg && bus.we && (wordIdx < protectLimit);
    assign fault     = misaligned || regBad || protFault;

    // Memory side, gated off on any fault
    assign memEn   = accept && !isReg && !fault;
    assign memWe   = memEn && bus.we;
    assign wordIdx = bus.adr[addrWidth+1:2];
    assign size    = bus.size;
    assign lane    = bus.adr[1:0];
    assign wdata   = bus.dat;

    // Register side
    assign regSel    = accept && isReg && !fault;
    assign regWe     = regSel && bus.we;
    assign regOffset = bus.adr[3:2];
    assign regWdata  = bus.dat;

    assign faultPulse = accept && fault;
    assign faultAddr  = bus.adr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ackQ <= 1'b0;
            errQ <= 1'b0;
        end else begin
            ackQ <= accept && !fault;  // High for the one cycle after accept
            errQ <= accept && fault;
        end
    end

    // Response source and load tags
    always_ff @(posedge clk) begin
        if (accept) begin
            srcRegQ     <= isReg;
            fmtSize     <= bus.size;
            fmtUnsigned <= bus.unsignedLoad;
        end
    end

    always_comb begin
        rsp.ack = ackQ;
        rsp.err = errQ;
        rsp.dat = srcRegQ ? regRdata : memLoadData;
    end

endmodule

`default_nettype wire

// ==== logic/memCtrlRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protect limit plus fault status registers
module memCtrlRegs
    import memPkg::*;
#(
    parameter int addrWidth = 10
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 sel,
    input  logic                 we,
    input  logic [1:0]           offset,       // Word offset in the window
    input  wordT                 wdata,
    input  logic                 faultPulse,
    input  byteAddrT             faultAddr,
    output wordT                 rdata,
    output logic [addrWidth-1:0] protectLimit  // Stores below this word index fail
);

    wordT     faultCount;     // Saturating
    byteAddrT lastFaultAddr;
    logic     limitWr;
    logic     countWr;

    assign limitWr = sel && we && (offset == regProtectLimit[3:2]);
    assign countWr = sel && we && (offset == regFaultCount[3:2]);  // Write of any value clears

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            protectLimit  <= '0;  // Nothing protected
            faultCount    <= '0;
            lastFaultAddr <= '0;
        end else begin
            if (limitWr) begin
                protectLimit <= wdata[addrWidth-1:0];
            end
            // Clear wins, a fault never coincides with a register write
            if (countWr) begin
                faultCount <= '0;
            end else if (faultPulse && (faultCount != '1)) begin
                faultCount <= faultCount + 1'b1;
            end
            if (faultPulse) begin
                lastFaultAddr <= faultAddr;
            end
        end
    end

    // Read data held for the ack cycle
    always_ff @(posedge clk) begin
        if (sel && !we) begin
            case (offset)
                regProtectLimit[3:2]: rdata <= wordT'(protectLimit);
                regFaultCount[3:2]:   rdata <= faultCount;
                regFaultAddr[3:2]:    rdata <= lastFaultAddr;
                default:              rdata <= '0;  // Unmapped slot
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/dataMemTop.sv ====
`timescale 1ns/1ps
`default_nettype none

// Data memory with its Wishbone slave and control registers
module dataMemTop
    import memPkg::*;
#(
    parameter int addrWidth = 10  // RAM depth is 2**addrWidth words
) (
    input  logic  clk,
    input  logic  rstN,
    input  wbReqT bus,
    output wbRspT rsp
);

    logic                 memEn;
    logic                 memWe;
    logic [addrWidth-1:0] wordIdx;
    accSizeT              size;
    logic [1:0]           lane;
    wordT                 wdata;
    logic                 regSel;
    logic                 regWe;
    logic [1:0]           regOffset;
    wordT                 regWdata;
    logic                 faultPulse;
    byteAddrT             faultAddr;
    accSizeT              fmtSize;
    logic                 fmtUnsigned;
    logic [addrWidth-1:0] protectLimit;
    wordT                 memRaw;       // Lane-aligned RAM word
    wordT                 loadData;     // Extended load
    wordT                 regRdata;

    wbMemSlave #(.addrWidth(addrWidth)) uSlave (
        .clk(clk), .rstN(rstN), .bus(bus), .rsp(rsp),
        .memEn(memEn), .memWe(memWe), .wordIdx(wordIdx), .size(size),
        .lane(lane), .wdata(wdata),
        .regSel(regSel), .regWe(regWe), .regOffset(regOffset), .regWdata(regWdata),
        .faultPulse(faultPulse), .faultAddr(faultAddr),
        .fmtSize(fmtSize), .fmtUnsigned(fmtUnsigned),
        .protectLimit(protectLimit), .memLoadData(loadData), .regRdata(regRdata)
    );

    dataMem #(.addrWidth(addrWidth)) uRam (
        .clk(clk), .en(memEn), .we(memWe), .wordIdx(wordIdx),
        .size(size), .lane(lane), .wdata(wdata), .rdata(memRaw)
    );

    loadFormat uFormat (
        .size(fmtSize), .unsignedLoad(fmtUnsigned), .rawData(memRaw), .loadData(loadData)
    );

    memCtrlRegs #(.addrWidth(addrWidth)) uRegs (
        .clk(clk), .rstN(rstN), .sel(regSel), .we(regWe), .offset(regOffset),
        .wdata(regWdata), .faultPulse(faultPulse), .faultAddr(faultAddr),
        .rdata(regRdata), .protectLimit(protectLimit)
    );

endmodule

`default_nettype wire

// ==== verification/dataMemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the Wishbone data memory with its control registers
module dataMemTb
    import memPkg::*;
();

    localparam int addrWidth       = 10;
    localparam int clkPeriod       = 40;    // ns
    localparam int regionBytes     = 256;   // Test region of 64 words
    localparam int numRandom       = 200;
    localparam int numAccesses     = regionBytes / 4 + numRandom + 40;
    localparam int cyclesPerAccess = 2;     // Request cycle plus ack cycle
    localparam int watchdogCycles  = numAccesses * cyclesPerAccess + 100;
    localparam byteAddrT regBase   = byteAddrT'(1) << regWinBit;

    logic       clk;
    logic       rstN;
    wbReqT      bus;
    wbRspT      rsp;
    logic       accepted;
    logic [7:0] model [regionBytes];  // Byte-addressed reference memory
    int         expFaults;
    byteAddrT   expFaultAddr;

    dataMemTop #(.addrWidth(addrWidth)) u_dut (.clk(clk), .rstN(rstN), .bus(bus), .rsp(rsp));

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic stopOnError(input string why);
        $display("** FAIL **");
        $display("%s", why);
        $fatal(1, "Run stopped at the first error");
    endtask

    // Request taken at this edge when nothing is in flight
    assign accepted = bus.cyc && bus.stb && !rsp.ack && !rsp.err;

    respAfterAccept: assert property (@(posedge clk) disable iff (!rstN)
        accepted |=> (rsp.ack ^ rsp.err))
        else stopOnError("Protocol error: accepted request got no single ack or err");
    quietWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
        !accepted |=> !(rsp.ack || rsp.err))
        else stopOnError("Protocol error: response without an accepted request");
    neverBoth: assert property (@(posedge clk) disable iff (!rstN) !(rsp.ack && rsp.err))
        else stopOnError("Protocol error: ack and err high together");

    task automatic checkWord(input string name, input wordT exp, input wordT act);
        assert (act === exp)
            else stopOnError($sformatf("Mismatch %s expected %08h actual %08h", name, exp, act));
    endtask

    function automatic int sizeBytes(input accSizeT size);
        case (size)
            sizeWord: return 4;
            sizeHalf: return 2;
            default:  return 1;
        endcase
    endfunction

    // Little-endian lanes with byte address a at bits 8*(a%4)
    function automatic void storeModel(input byteAddrT adr, input wordT dat, input accSizeT size);
        for (int i = 0; i < sizeBytes(size); i++) begin
            model[adr + i] = dat[8*i +: 8];
        end
    endfunction

    function automatic wordT expectLoad(input byteAddrT adr, input accSizeT size, input logic uns);
        wordT raw;
        raw = '0;
        for (int i = 0; i < sizeBytes(size); i++) begin
            raw[8*i +: 8] = model[adr + i];
        end
        if (size == sizeByte && !uns && raw[7]) begin
            raw[31:8] = '1;   // LB sign fill
        end
        if (size == sizeHalf && !uns && raw[15]) begin
            raw[31:16] = '1;  // LH sign fill
        end
        return raw;
    endfunction

    // One Wishbone classic cycle driven on falling edges
    task automatic busAccess(input logic we, input byteAddrT adr, input wordT dat,
                             input accSizeT size, input logic uns,
                             output wordT rdat, output logic gotErr);
        int waited;
        waited = 0;
        @(negedge clk);
        bus.cyc          = 1'b1;
        bus.stb          = 1'b1;
        bus.we           = we;
        bus.adr          = adr;
        bus.dat          = dat;
        bus.size         = size;
        bus.unsignedLoad = uns;
        @(negedge clk);
        while (!(rsp.ack || rsp.err)) begin
            waited++;
            if (waited > 8) begin
                stopOnError($sformatf("No ack or err for the access to %08h", adr));
            end
            @(negedge clk);
        end
        rdat    = rsp.dat;  // Stable in the middle of the ack cycle
        gotErr  = rsp.err;
        bus.cyc = 1'b0;
        bus.stb = 1'b0;
    endtask

    task automatic storeOk(input string name, input byteAddrT adr, input wordT dat,
                           input accSizeT size);
        wordT rdat;
        logic gotErr;
        busAccess(1'b1, adr, dat, size, 1'b0, rdat, gotErr);
        assert (!gotErr) else stopOnError($sformatf("%s: store to %08h got err", name, adr));
        storeModel(adr, dat, size);
    endtask

    task automatic loadCheck(input string name, input byteAddrT adr, input accSizeT size,
                             input logic uns);
        wordT rdat;
        logic gotErr;
        busAccess(1'b0, adr, '0, size, uns, rdat, gotErr);
        assert (!gotErr) else stopOnError($sformatf("%s: load from %08h got err", name, adr));
        checkWord($sformatf("%s @%08h", name, adr), expectLoad(adr, size, uns), rdat);
    endtask

    task automatic expectErr(input string name, input logic we, input byteAddrT adr,
                             input wordT dat, input accSizeT size);
        wordT rdat;
        logic gotErr;
        busAccess(we, adr, dat, size, 1'b0, rdat, gotErr);
        assert (gotErr)
            else stopOnError($sformatf("%s: access to %08h was not refused", name, adr));
        expFaults++;
        expFaultAddr = adr;
    endtask

    task automatic regWrite(input logic [3:0] offset, input wordT dat);
        wordT rdat;
        logic gotErr;
        busAccess(1'b1, regBase | byteAddrT'(offset), dat, sizeWord, 1'b0, rdat, gotErr);
        assert (!gotErr) else stopOnError($sformatf("Register write at %0h got err", offset));
    endtask

    task automatic regCheck(input string name, input logic [3:0] offset, input wordT exp);
        wordT rdat;
        logic gotErr;
        busAccess(1'b0, regBase | byteAddrT'(offset), '0, sizeWord, 1'b0, rdat, gotErr);
        assert (!gotErr) else stopOnError($sformatf("Register read at %0h got err", offset));
        checkWord(name, exp, rdat);
    endtask

    function automatic accSizeT randomSize();
        case ($urandom_range(2))
            0:       return sizeWord;
            1:       return sizeHalf;
            default: return sizeByte;
        endcase
    endfunction

    initial begin
        byteAddrT adr;
        accSizeT  size;
        void'($urandom(32'ha83d));
        rstN         = 1'b0;
        bus          = '0;
        expFaults    = 0;
        expFaultAddr = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        assert (!rsp.ack && !rsp.err) else stopOnError("ack or err high right after reset");

        for (int w = 0; w < regionBytes / 4; w++) begin
            storeOk("fill", byteAddrT'(w * 4), $urandom, sizeWord);  // Defined contents
        end

        // Random sized traffic in the test region
        for (int i = 0; i < numRandom; i++) begin
            size = randomSize();
            adr  = byteAddrT'($urandom_range(regionBytes - 1));
            if (size == sizeWord) begin
                adr[1:0] = 2'b00;
            end else if (size == sizeHalf) begin
                adr[0] = 1'b0;
            end
            if ($urandom_range(1) == 1) begin
                storeOk("random store", adr, $urandom, size);
            end else begin
                loadCheck("random load", adr, size, $urandom_range(1) == 1);
            end
        end

        // Sign and zero extension
        storeOk("ext word", 32'h20, 32'h80ff7f80, sizeWord);
        loadCheck("lb neg", 32'h20, sizeByte, 1'b0);
        loadCheck("lbu neg", 32'h20, sizeByte, 1'b1);
        loadCheck("lb pos", 32'h21, sizeByte, 1'b0);
        loadCheck("lh neg", 32'h22, sizeHalf, 1'b0);
        loadCheck("lhu neg", 32'h22, sizeHalf, 1'b1);
        loadCheck("lh pos", 32'h20, sizeHalf, 1'b0);

        // Misaligned and illegal sizes leave the memory untouched
        regWrite(regFaultCount, '0);
        expFaults = 0;
        expectErr("odd half store", 1'b1, 32'h41, 32'h1111_2222, sizeHalf);
        expectErr("unaligned word store", 1'b1, 32'h42, 32'h3333_4444, sizeWord);
        expectErr("size 3 store", 1'b1, 32'h40, 32'h5555_6666, 2'b11);
        expectErr("odd half load", 1'b0, 32'h43, '0, sizeHalf);
        loadCheck("word after faults", 32'h40, sizeWord, 1'b0);
        regCheck("fault count misaligned", regFaultCount, wordT'(expFaults));
        regCheck("fault addr misaligned", regFaultAddr, expFaultAddr);

        // Write protection below word index 32
        regWrite(regProtectLimit, 32'd32);
        regCheck("protect limit", regProtectLimit, 32'd32);
        expectErr("protected word store", 1'b1, 32'h28, 32'hdead_beef, sizeWord);
        loadCheck("protected word kept", 32'h28, sizeWord, 1'b0);
        regCheck("fault addr protected", regFaultAddr, expFaultAddr);
        expectErr("protected byte store", 1'b1, 32'h7f, 32'h0000_00aa, sizeByte);
        storeOk("store at limit", 32'h80, 32'hcafe_f00d, sizeWord);
        loadCheck("word at limit", 32'h80, sizeWord, 1'b0);
        regCheck("fault count protected", regFaultCount, wordT'(expFaults));
        regCheck("fault addr last", regFaultAddr, expFaultAddr);
        regWrite(regProtectLimit, '0);

        // Any write clears the counter
        regWrite(regFaultCount, 32'h0000_5a5a);
        regCheck("fault count cleared", regFaultCount, '0);

        $display("** PASS **");
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        stopOnError("Watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// ==== dataMemTop.f ====
logic/memPkg.sv
logic/dataMem.sv
logic/loadFormat.sv
logic/wbMemSlave.sv
logic/memCtrlRegs.sv
logic/dataMemTop.sv
verification/dataMemTb.sv
